// ==== logic/ppuBus_defs.svh ====
`ifndef PPU_BUS_DEFS_SVH
`define PPU_BUS_DEFS_SVH

// ************************************************************
// frame timing
// ************************************************************

// cycles per line and lines per frame
`define PPU_LINE_CYCLES 341
`define PPU_FRAME_LINES 262

// vblank starts here
`define PPU_VBLANK_LINE 241
// and ends here
`define PPU_PRERENDER_LINE 261

// ************************************************************
// bus widths and address map
// ************************************************************

`define PPU_DATA_WIDTH 8
`define PPU_ADDR_WIDTH 14

// palette is mapped at the top of VRAM space but lives on chip
`define PPU_PALETTE_BASE 14'h3F00
`define PPU_PALETTE_ENTRIES 32

// VRAM address step for register 7 when control bit 2 is set
`define PPU_INC_WIDE 32

`endif

// ==== logic/ppuPkg.sv ====
`default_nettype none

package ppuPkg;

	// external VRAM bus sequencer states
	typedef enum logic [1:0]
	{
		busIdle      = 2'd0,
		busAddrLatch = 2'd1,
		busWrite     = 2'd2,
		busRead      = 2'd3
	} ppuBusState;

	// CPU visible register indices
	typedef enum logic [2:0]
	{
		regCtrl    = 3'd0,
		regMask    = 3'd1,
		regStatus  = 3'd2,
		regOamAddr = 3'd3,
		regOamData = 3'd4,
		regScroll  = 3'd5,
		regAddr    = 3'd6,
		regData    = 3'd7
	} ppuRegIndex;

endpackage

`default_nettype wire

// ==== logic/frameTimer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ppuBus_defs.svh"

module frameTimer
	import ppuPkg::*;
(
	input wire logic ppuCLK_div4,
	input wire logic reset_ppuCLK_div4,
	input wire logic ctrlNmiEnable,
	input wire logic statusRead,
	output logic vblank,
	output logic cpuIntN
);

	logic [8:0] hCount;
	logic [8:0] vCount;
	logic lineEnd;
	logic vblankStart;

	assign lineEnd = (hCount == `PPU_LINE_CYCLES - 1);

	// the edge that moves the count to line 241, cycle 0
	assign vblankStart = lineEnd && (vCount == `PPU_VBLANK_LINE - 1);

	// ************************************************************
	// line and frame counters
	// ************************************************************

	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
		begin
			hCount <= '0;
			vCount <= '0;
		end
		else if (!lineEnd)
			hCount <= hCount + 9'd1;
		else
		begin
			hCount <= '0;
			if (vCount == `PPU_FRAME_LINES - 1)
				vCount <= '0;
			else
				vCount <= vCount + 9'd1;
		end
	end

	// vblank flag and interrupt share set and clear conditions
	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
		begin
			vblank <= 1'b0;
			cpuIntN <= 1'b1;
		end
		else if (vblankStart)
		begin
			vblank <= 1'b1;
			// interrupt only if the CPU asked for it
			cpuIntN <= ~ctrlNmiEnable;
		end
		else if (statusRead || (vCount == `PPU_PRERENDER_LINE))
		begin
			vblank <= 1'b0;
			cpuIntN <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== logic/cpuRegFile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ppuBus_defs.svh"

module cpuRegFile
	import ppuPkg::*;
(
	input wire logic ppuCLK_div4,
	input wire logic reset_ppuCLK_div4,
	input wire ppuRegIndex cpuA,
	input wire logic cpuRw,
	input wire logic cpuCsN,
	input wire logic [`PPU_DATA_WIDTH-1:0] cpuWrData,
	output logic [`PPU_DATA_WIDTH-1:0] cpuRdData,
	input wire logic vblank,
	output logic ctrlNmiEnable,
	output logic statusRead,
	output logic vramReq,
	output logic vramRw,
	output logic [`PPU_ADDR_WIDTH-1:0] vramAddr,
	output logic [`PPU_DATA_WIDTH-1:0] vramWrData,
	input wire logic [`PPU_DATA_WIDTH-1:0] vramReadBuf
);

	localparam int palIdxWidth = $clog2(`PPU_PALETTE_ENTRIES);
	localparam logic [`PPU_ADDR_WIDTH-1:0] incWide = `PPU_INC_WIDE;

	logic csPrevHigh;
	logic csTake;
	logic byteLatch;
	logic [`PPU_DATA_WIDTH-1:0] ctrlReg;
	logic [`PPU_DATA_WIDTH-1:0] maskReg;
	logic [`PPU_DATA_WIDTH-1:0] oamAddr;
	logic [`PPU_ADDR_WIDTH-1:0] vAddr;
	logic [`PPU_ADDR_WIDTH-1:0] addrStep;
	logic isPalette;
	logic [palIdxWidth-1:0] paletteIdx;
	logic [5:0] paletteRam [`PPU_PALETTE_ENTRIES];
	logic [`PPU_DATA_WIDTH-1:0] readMux;
	logic [`PPU_DATA_WIDTH-1:0] readHold;

	// ************************************************************
	// chip select qualification
	// ************************************************************

	// one action per chip select assertion
	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
			csPrevHigh <= 1'b1;
		else
			csPrevHigh <= cpuCsN;
	end

	assign csTake = !cpuCsN && csPrevHigh;
	assign statusRead = csTake && cpuRw && (cpuA == regStatus);
	assign ctrlNmiEnable = ctrlReg[7];

	assign addrStep = ctrlReg[2] ? incWide : `PPU_ADDR_WIDTH'(1);
	assign isPalette = (vAddr >= `PPU_PALETTE_BASE);

	// entry 0 is shared by all palettes with low nibble 0
	assign paletteIdx = (vAddr[3:0] == 4'h0) ? '0 : vAddr[palIdxWidth-1:0];

	// ************************************************************
	// register storage
	// ************************************************************

	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
		begin
			ctrlReg <= '0;
			maskReg <= '0;
			oamAddr <= '0;
			vAddr <= '0;
			byteLatch <= 1'b0;
		end
		else if (csTake)
		begin
			case (cpuA)
				regCtrl:
					if (!cpuRw)
						ctrlReg <= cpuWrData;
				regMask:
					if (!cpuRw)
						maskReg <= cpuWrData;
				regStatus:
					if (cpuRw)
						byteLatch <= 1'b0;
				regOamAddr:
					if (!cpuRw)
						oamAddr <= cpuWrData;
				regOamData:
					// no OAM behind this so only the address steps
					if (!cpuRw)
						oamAddr <= oamAddr + 8'd1;
				regScroll:
					byteLatch <= ~byteLatch;
				regAddr:
				begin
					byteLatch <= ~byteLatch;
					if (!cpuRw)
					begin
						if (!byteLatch)
							vAddr[13:8] <= cpuWrData[5:0];
						else
							vAddr[7:0] <= cpuWrData;
					end
				end
				regData:
					vAddr <= vAddr + addrStep;
				default:
				begin
				end
			endcase
		end
	end

	// palette writes stay on chip
	always_ff @(posedge ppuCLK_div4)
	begin
		if (csTake && !cpuRw && (cpuA == regData) && isPalette)
			paletteRam[paletteIdx] <= cpuWrData[5:0];
	end

	// ************************************************************
	// VRAM request toward the bus sequencer
	// ************************************************************

	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
		begin
			vramReq <= 1'b0;
			vramRw <= 1'b1;
		end
		else if (csTake && (cpuA == regData) && !isPalette)
		begin
			vramReq <= ~vramReq;
			vramRw <= cpuRw;
		end
	end

	always_ff @(posedge ppuCLK_div4)
	begin
		if (csTake && (cpuA == regData) && !isPalette)
		begin
			vramAddr <= vAddr;
			vramWrData <= cpuWrData;
		end
	end

	// ************************************************************
	// CPU read data
	// ************************************************************

	always_comb
	begin
		readMux = '0;
		case (cpuA)
			regCtrl:    readMux = ctrlReg;
			regMask:    readMux = maskReg;
			regStatus:  readMux = {vblank, 7'b0000000};
			regOamAddr: readMux = oamAddr;
			regOamData: readMux = '0;
			regScroll:  readMux = '0;
			regAddr:    readMux = byteLatch ? vAddr[7:0] : {2'b00, vAddr[13:8]};
			regData:    readMux = isPalette ? {2'b00, paletteRam[paletteIdx]} : vramReadBuf;
			default:    readMux = '0;
		endcase
	end

	// snapshot before this access changes status, address or latch
	always_ff @(posedge ppuCLK_div4)
	begin
		if (csTake)
			readHold <= readMux;
	end

	// presented to the CPU half a cycle later
	always_ff @(negedge ppuCLK_div4)
	begin
		cpuRdData <= readHold;
	end

endmodule

`default_nettype wire

// ==== logic/vramBusCtrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ppuBus_defs.svh"

module vramBusCtrl
	import ppuPkg::*;
(
	input wire logic ppuCLK_div4,
	input wire logic reset_ppuCLK_div4,
	input wire logic vramReq,
	input wire logic vramRw,
	input wire logic [`PPU_ADDR_WIDTH-1:0] vramAddr,
	input wire logic [`PPU_DATA_WIDTH-1:0] vramWrData,
	output logic vramDone,
	input wire logic [`PPU_DATA_WIDTH-1:0] ppuAdIn,
	output logic [`PPU_DATA_WIDTH-1:0] ppuAdOut,
	output logic ppuAdOe,
	output logic [5:0] ppuAUpper,
	output logic ppuAle,
	output logic ppuRdN,
	output logic ppuWrN,
	output logic ppuAdDir,
	output logic [`PPU_DATA_WIDTH-1:0] vramReadBuf
);

	ppuBusState busState;
	logic reqPending;

	assign reqPending = (vramReq != vramDone);

	// ************************************************************
	// bus sequencer
	// ************************************************************

	always_ff @(posedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
		begin
			busState <= busIdle;
			vramDone <= 1'b0;
		end
		else
		begin
			case (busState)
				busIdle:
					if (reqPending)
					begin
						busState <= busAddrLatch;
						vramDone <= ~vramDone;
					end
				busAddrLatch:
					busState <= vramRw ? busRead : busWrite;
				default:
					busState <= busIdle;
			endcase
		end
	end

	// address first, then write data on the same pins
	always_ff @(posedge ppuCLK_div4)
	begin
		if ((busState == busIdle) && reqPending)
		begin
			ppuAdOut <= vramAddr[7:0];
			ppuAUpper <= vramAddr[13:8];
		end
		else if (busState == busAddrLatch)
			ppuAdOut <= vramWrData;
	end

	// strobes decoded straight from the state
	assign ppuAle = (busState == busAddrLatch);
	assign ppuWrN = (busState != busWrite);
	assign ppuRdN = (busState != busRead);
	assign ppuAdOe = (busState == busAddrLatch) || (busState == busWrite);
	// high means the AD transceiver points out of the chip
	assign ppuAdDir = (busState != busRead);

	// sample mid strobe for setup margin
	always_ff @(negedge ppuCLK_div4, negedge reset_ppuCLK_div4)
	begin
		if (!reset_ppuCLK_div4)
			vramReadBuf <= '0;
		else if (busState == busRead)
			vramReadBuf <= ppuAdIn;
	end

endmodule

`default_nettype wire

// ==== logic/universalPpu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ppuBus_defs.svh"

module universalPpu
	import ppuPkg::*;
(
	input wire logic ppuCLK_div4,
	input wire logic reset_ppuCLK_div4,

	// CPU bus
	input wire ppuRegIndex cpuA,
	input wire logic cpuRw,
	input wire logic cpuCsN,
	inout wire [`PPU_DATA_WIDTH-1:0] cpuD,
	output logic cpuDDir,
	output logic cpuIntN,

	// VRAM bus
	inout wire [`PPU_DATA_WIDTH-1:0] ppuAd,
	output logic [5:0] ppuAUpper,
	output logic ppuAle,
	output logic ppuRdN,
	output logic ppuWrN,
	output logic ppuAdDir
);

	logic ctrlNmiEnable;
	logic statusRead;
	logic vblank;
	logic [`PPU_DATA_WIDTH-1:0] cpuRdData;
	logic vramReq;
	logic vramRw;
	logic vramDone;
	logic [`PPU_ADDR_WIDTH-1:0] vramAddr;
	logic [`PPU_DATA_WIDTH-1:0] vramWrData;
	logic [`PPU_DATA_WIDTH-1:0] vramReadBuf;
	logic [`PPU_DATA_WIDTH-1:0] ppuAdOut;
	logic ppuAdOe;

	// ************************************************************
	// pad drivers
	// ************************************************************

	assign cpuDDir = cpuRw && !cpuCsN;
	assign cpuD = cpuDDir ? cpuRdData : 'z;
	assign ppuAd = ppuAdOe ? ppuAdOut : 'z;

	frameTimer frameTimerInst
	(
		.ppuCLK_div4(ppuCLK_div4),
		.reset_ppuCLK_div4(reset_ppuCLK_div4),
		.ctrlNmiEnable(ctrlNmiEnable),
		.statusRead(statusRead),
		.vblank(vblank),
		.cpuIntN(cpuIntN)
	);

	cpuRegFile cpuRegFileInst
	(
		.ppuCLK_div4(ppuCLK_div4),
		.reset_ppuCLK_div4(reset_ppuCLK_div4),
		.cpuA(cpuA),
		.cpuRw(cpuRw),
		.cpuCsN(cpuCsN),
		.cpuWrData(cpuD),
		.cpuRdData(cpuRdData),
		.vblank(vblank),
		.ctrlNmiEnable(ctrlNmiEnable),
		.statusRead(statusRead),
		.vramReq(vramReq),
		.vramRw(vramRw),
		.vramAddr(vramAddr),
		.vramWrData(vramWrData),
		.vramReadBuf(vramReadBuf)
	);

	vramBusCtrl vramBusCtrlInst
	(
		.ppuCLK_div4(ppuCLK_div4),
		.reset_ppuCLK_div4(reset_ppuCLK_div4),
		.vramReq(vramReq),
		.vramRw(vramRw),
		.vramAddr(vramAddr),
		.vramWrData(vramWrData),
		.vramDone(vramDone),
		.ppuAdIn(ppuAd),
		.ppuAdOut(ppuAdOut),
		.ppuAdOe(ppuAdOe),
		.ppuAUpper(ppuAUpper),
		.ppuAle(ppuAle),
		.ppuRdN(ppuRdN),
		.ppuWrN(ppuWrN),
		.ppuAdDir(ppuAdDir),
		.vramReadBuf(vramReadBuf)
	);

endmodule

`default_nettype wire

// ==== verif/universalPpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ppuBus_defs.svh"

module universalPpuTb
	import ppuPkg::*;
();

	localparam int timeoutCycles = 100000;
	localparam int vramDepth = 1 << `PPU_ADDR_WIDTH;

	logic ppuCLK_div4;
	logic reset_ppuCLK_div4;
	ppuRegIndex cpuA;
	logic cpuRw;
	logic cpuCsN;
	wire [`PPU_DATA_WIDTH-1:0] cpuD;
	logic cpuDDir;
	logic cpuIntN;
	wire [`PPU_DATA_WIDTH-1:0] ppuAd;
	logic [5:0] ppuAUpper;
	logic ppuAle;
	logic ppuRdN;
	logic ppuWrN;
	logic ppuAdDir;

	logic [`PPU_DATA_WIDTH-1:0] cpuDrive;
	logic cpuDriveEn;
	logic [`PPU_DATA_WIDTH-1:0] vram [vramDepth];
	logic [`PPU_ADDR_WIDTH-1:0] modelAddr;
	logic [`PPU_ADDR_WIDTH-1:0] expAddr;
	logic [`PPU_ADDR_WIDTH-1:0] readBase;
	logic [`PPU_DATA_WIDTH-1:0] expBuf;

	universalPpu dut
	(
		.ppuCLK_div4(ppuCLK_div4),
		.reset_ppuCLK_div4(reset_ppuCLK_div4),
		.cpuA(cpuA),
		.cpuRw(cpuRw),
		.cpuCsN(cpuCsN),
		.cpuD(cpuD),
		.cpuDDir(cpuDDir),
		.cpuIntN(cpuIntN),
		.ppuAd(ppuAd),
		.ppuAUpper(ppuAUpper),
		.ppuAle(ppuAle),
		.ppuRdN(ppuRdN),
		.ppuWrN(ppuWrN),
		.ppuAdDir(ppuAdDir)
	);

	always #5 ppuCLK_div4 = ~ppuCLK_div4;

	assign cpuD = cpuDriveEn ? cpuDrive : 'z;

	// ************************************************************
	// VRAM model
	// ************************************************************

	// address is taken mid cycle while ALE is high
	always @(negedge ppuCLK_div4)
	begin
		if (ppuAle === 1'b1)
			modelAddr <= {ppuAUpper, ppuAd};
		if (ppuWrN === 1'b0)
			vram[modelAddr] <= ppuAd;
	end

	assign ppuAd = (ppuRdN === 1'b0) ? vram[modelAddr] : 'z;

	// ************************************************************
	// checks and bus helpers
	// ************************************************************

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compareByte(input logic [`PPU_DATA_WIDTH-1:0] got,
		input logic [`PPU_DATA_WIDTH-1:0] exp, input string what);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %02h expected %02h",
				$time, what, got, exp));
	endtask

	task automatic compareAddr(input logic [`PPU_ADDR_WIDTH-1:0] got,
		input logic [`PPU_ADDR_WIDTH-1:0] exp, input string what);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %04h expected %04h",
				$time, what, got, exp));
	endtask

	task automatic compareBit(input logic got, input logic exp, input string what);
		if (got !== exp)
			stopOnError($sformatf("MISMATCH at %0t ns: %s got %b expected %b",
				$time, what, got, exp));
	endtask

	// bus phase as seen on the pins
	function automatic ppuBusState busPhase();
		if (ppuAle === 1'b1)
			return busAddrLatch;
		if (ppuWrN === 1'b0)
			return busWrite;
		if (ppuRdN === 1'b0)
			return busRead;
		return busIdle;
	endfunction

	task automatic waitBusPhase(input ppuBusState target, input string what);
		int count;
		count = 0;
		do
		begin
			@(negedge ppuCLK_div4);
			count++;
			if (count > timeoutCycles)
				stopOnError($sformatf("timed out waiting for %s on the VRAM bus", what));
		end
		while (busPhase() != target);
	endtask

	task automatic writeReg(input ppuRegIndex idx, input logic [`PPU_DATA_WIDTH-1:0] data);
		@(negedge ppuCLK_div4);
		cpuA = idx;
		cpuRw = 1'b0;
		cpuDrive = data;
		cpuDriveEn = 1'b1;
		cpuCsN = 1'b0;
		@(negedge ppuCLK_div4);
		compareBit(cpuDDir, 1'b0, "cpuDDir during write");
		cpuCsN = 1'b1;
		cpuDriveEn = 1'b0;
		cpuRw = 1'b1;
	endtask

	// data is presented on the falling edge after the access edge
	task automatic readReg(input ppuRegIndex idx, output logic [`PPU_DATA_WIDTH-1:0] data);
		@(negedge ppuCLK_div4);
		cpuA = idx;
		cpuRw = 1'b1;
		cpuCsN = 1'b0;
		@(negedge ppuCLK_div4);
		@(posedge ppuCLK_div4);
		compareBit(cpuDDir, 1'b1, "cpuDDir during read");
		data = cpuD;
		@(negedge ppuCLK_div4);
		cpuCsN = 1'b1;
	endtask

	task automatic setVramAddr(input logic [`PPU_ADDR_WIDTH-1:0] addr);
		logic [`PPU_DATA_WIDTH-1:0] dummy;
		// status read resets the byte latch
		readReg(regStatus, dummy);
		writeReg(regAddr, {2'b00, addr[13:8]});
		writeReg(regAddr, addr[7:0]);
		expAddr = addr;
	endtask

	task automatic busCycle(input logic isRead, input logic [`PPU_DATA_WIDTH-1:0] data);
		waitBusPhase(busAddrLatch, "ALE");
		compareAddr({ppuAUpper, ppuAd}, expAddr, "VRAM address at ALE");
		if (isRead)
		begin
			waitBusPhase(busRead, "read strobe");
			compareBit(ppuAdDir, 1'b0, "ppuAdDir during read");
		end
		else
		begin
			waitBusPhase(busWrite, "write strobe");
			compareByte(ppuAd, data, "write data on ppuAd");
		end
		waitBusPhase(busIdle, "end of bus cycle");
	endtask

	task automatic vramWrite(input logic [`PPU_DATA_WIDTH-1:0] data, input int step);
		fork
			writeReg(regData, data);
			busCycle(1'b0, data);
		join
		compareByte(vram[expAddr], data, "byte stored in VRAM model");
		expAddr = expAddr + `PPU_ADDR_WIDTH'(step);
	endtask

	task automatic vramRead(input int step);
		logic [`PPU_DATA_WIDTH-1:0] got;
		fork
			readReg(regData, got);
			busCycle(1'b1, 8'h00);
		join
		compareByte(got, expBuf, "register 7 read buffer");
		expBuf = vram[expAddr];
		expAddr = expAddr + `PPU_ADDR_WIDTH'(step);
	endtask

	// ************************************************************
	// directed tests
	// ************************************************************

	task automatic checkAfterReset();
		logic [`PPU_DATA_WIDTH-1:0] got;
		compareBit(cpuIntN, 1'b1, "cpuIntN after reset");
		compareBit(ppuRdN, 1'b1, "ppuRdN after reset");
		compareBit(ppuWrN, 1'b1, "ppuWrN after reset");
		compareBit(ppuAle, 1'b0, "ppuAle after reset");
		readReg(regStatus, got);
		compareBit(got[7], 1'b0, "status vblank after reset");
	endtask

	task automatic checkRegReadback();
		logic [`PPU_DATA_WIDTH-1:0] val;
		logic [`PPU_DATA_WIDTH-1:0] got;
		// keep NMI enable and wide step off for now
		val = 8'($urandom()) & 8'h7B;
		writeReg(regCtrl, val);
		readReg(regCtrl, got);
		compareByte(got, val, "control readback");
		val = 8'($urandom());
		writeReg(regMask, val);
		readReg(regMask, got);
		compareByte(got, val, "mask readback");
		val = 8'($urandom());
		writeReg(regOamAddr, val);
		readReg(regOamAddr, got);
		compareByte(got, val, "OAM address readback");
		for (int i = 0; i < 3; i++)
		begin
			writeReg(regOamData, 8'($urandom()));
			val = val + 8'd1;
			readReg(regOamAddr, got);
			compareByte(got, val, "OAM address after OAM data write");
		end
	endtask

	task automatic checkVramWrites();
		readBase = 14'($urandom()) & 14'h1FFF;
		setVramAddr(readBase);
		vramWrite(8'($urandom()), 1);
		vramWrite(8'($urandom()), 1);
		writeReg(regCtrl, 8'h04);
		vramWrite(8'($urandom()), `PPU_INC_WIDE);
		vramWrite(8'($urandom()), `PPU_INC_WIDE);
		writeReg(regCtrl, 8'h00);
	endtask

	// each read returns what the previous one fetched
	task automatic checkVramReads();
		setVramAddr(readBase);
		for (int i = 0; i < 3; i++)
			vramRead(1);
	endtask

	task automatic checkPalette();
		logic [`PPU_DATA_WIDTH-1:0] val;
		logic [`PPU_DATA_WIDTH-1:0] got;
		val = 8'($urandom());
		setVramAddr(`PPU_PALETTE_BASE + 14'h05);
		writeReg(regData, val);
		repeat (6)
		begin
			@(negedge ppuCLK_div4);
			compareBit(ppuAle, 1'b0, "ppuAle on palette write");
			compareBit(ppuWrN, 1'b1, "ppuWrN on palette write");
			compareBit(ppuRdN, 1'b1, "ppuRdN on palette write");
		end
		setVramAddr(`PPU_PALETTE_BASE + 14'h05);
		readReg(regData, got);
		compareByte(got, {2'b00, val[5:0]}, "palette entry readback");
	endtask

	task automatic checkVblankIrq();
		logic [`PPU_DATA_WIDTH-1:0] got;
		int count;
		writeReg(regCtrl, 8'h80);
		count = 0;
		while (cpuIntN !== 1'b0)
		begin
			@(negedge ppuCLK_div4);
			count++;
			if (count > timeoutCycles)
				stopOnError("timed out waiting for cpuIntN to fall at vblank");
		end
		readReg(regStatus, got);
		compareBit(got[7], 1'b1, "status vblank at interrupt");
		compareBit(cpuIntN, 1'b1, "cpuIntN after status read");
		readReg(regStatus, got);
		compareBit(got[7], 1'b0, "status vblank after second read");
	endtask

	initial
	begin
		int seed;
		seed = 24;
		void'($urandom(seed));
		ppuCLK_div4 = 1'b0;
		reset_ppuCLK_div4 = 1'b0;
		cpuA = regCtrl;
		cpuRw = 1'b1;
		cpuCsN = 1'b1;
		cpuDrive = '0;
		cpuDriveEn = 1'b0;
		expAddr = '0;
		expBuf = '0;
		readBase = '0;
		// every address bit shows up in the fill byte
		for (int i = 0; i < vramDepth; i++)
			vram[i] = 8'(i ^ (i >> 6) ^ 8'h5A);
		repeat (3) @(posedge ppuCLK_div4);
		@(negedge ppuCLK_div4);
		reset_ppuCLK_div4 = 1'b1;

		checkAfterReset();
		checkRegReadback();
		checkVramWrites();
		checkVramReads();
		checkPalette();
		checkVblankIrq();

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== universalPpu.f ====
+incdir+logic
logic/ppuPkg.sv
logic/frameTimer.sv
logic/cpuRegFile.sv
logic/vramBusCtrl.sv
logic/universalPpu.sv
verif/universalPpuTb.sv
